//--- ex_isa_pkg.sv
`default_nettype none

package ex_isa_pkg;

    // Opcode values as decoded upstream
    typedef enum logic [7:0] {
        OP_NOP   = 8'b00000000,
        OP_OR    = 8'b00100101,
        OP_AND   = 8'b00100100,
        OP_XOR   = 8'b00100110,
        OP_NOR   = 8'b00100111,
        OP_SRL   = 8'b00000010,
        OP_SRA   = 8'b00000011,
        OP_SLL   = 8'b01111100,
        OP_ADD   = 8'b00100000,
        OP_ADDU  = 8'b00100001,
        OP_SUB   = 8'b00100010,
        OP_SUBU  = 8'b00100011,
        OP_SLT   = 8'b00101010,
        OP_SLTU  = 8'b00101011,
        OP_CLZ   = 8'b10110000,
        OP_CLO   = 8'b10110001,
        OP_MUL   = 8'b10101001,
        OP_MULT  = 8'b00011000,
        OP_MULTU = 8'b00011001,
        OP_MFHI  = 8'b00010000,
        OP_MTHI  = 8'b00010001,
        OP_MFLO  = 8'b00010010,
        OP_MTLO  = 8'b00010011,
        OP_MADD  = 8'b10100110,
        OP_MADDU = 8'b10101000,
        OP_MSUB  = 8'b10101010,
        OP_MSUBU = 8'b10101011
    } alu_op_e;

    // Multiply-accumulate sequencer
    typedef enum logic {
        ACC_IDLE = 1'b0,   // Product not yet captured
        ACC_SUM  = 1'b1    // Adding captured term into HI/LO
    } acc_state_e;

endpackage

`default_nettype wire

//--- ex_types_pkg.sv
`default_nettype none

package ex_types_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;

    typedef struct packed {
        ex_isa_pkg::alu_op_e alu_op;
        word_t               src_data1;
        word_t               src_data2;
        reg_addr_t           wr_addr;
        logic                wr_en;
    } ex_req_t;

    typedef struct packed {
        reg_addr_t addr;
        word_t     data;
        logic      en;
    } gpr_wb_t;

    typedef struct packed {
        word_t hi;
        word_t lo;
    } hilo_t;

    typedef struct packed {
        logic  en;
        hilo_t value;
    } hilo_wr_t;

endpackage

`default_nettype wire

//--- ex_bitwise.sv
`timescale 1ns/1ps
`default_nettype none

module ex_bitwise (
    input  ex_types_pkg::ex_req_t req,
    output ex_types_pkg::word_t   bitwise_result
);

    ex_types_pkg::shamt_t shamt;
    ex_types_pkg::word_t  sra_result;

    assign shamt = req.src_data1[4:0];   // Shift count from rs low bits

    // Arithmetic right shift keeps the sign of the shifted word
    assign sra_result = ex_types_pkg::word_t'($signed(req.src_data2) >>> shamt);

    always_comb begin
        case (req.alu_op)
            ex_isa_pkg::OP_AND: begin
                bitwise_result = req.src_data1 & req.src_data2;
            end
            ex_isa_pkg::OP_OR: begin
                bitwise_result = req.src_data1 | req.src_data2;
            end
            ex_isa_pkg::OP_XOR: begin
                bitwise_result = req.src_data1 ^ req.src_data2;
            end
            ex_isa_pkg::OP_NOR: begin
                bitwise_result = ~(req.src_data1 | req.src_data2);
            end
            ex_isa_pkg::OP_SRL: begin
                bitwise_result = req.src_data2 >> shamt;
            end
            ex_isa_pkg::OP_SRA: begin
                bitwise_result = sra_result;
            end
            ex_isa_pkg::OP_SLL: begin
                bitwise_result = req.src_data2 << shamt;
            end
            default: begin
                bitwise_result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- ex_arith.sv
`timescale 1ns/1ps
`default_nettype none

module ex_arith (
    input  ex_types_pkg::ex_req_t req,
    output ex_types_pkg::word_t   arith_result,
    output logic                  overflow
);

    logic                is_sub;
    ex_types_pkg::word_t add_b;
    ex_types_pkg::word_t sum;
    logic                slt_less;
    logic                sltu_less;
    ex_types_pkg::word_t count_src;
    logic [5:0]          lead_count;

    // Highest set bit wins, all-zero word gives 32
    function automatic logic [5:0] lead_zeros(input ex_types_pkg::word_t w);
        logic [5:0] n;
        n = 6'd32;
        for (int i = 0; i < 32; i++) begin
            if (w[i]) begin
                n = 6'(31 - i);
            end
        end
        return n;
    endfunction

    assign is_sub = (req.alu_op == ex_isa_pkg::OP_SUB) ||
                    (req.alu_op == ex_isa_pkg::OP_SUBU) ||
                    (req.alu_op == ex_isa_pkg::OP_SLT);

    // Two's complement as inverted operand plus carry in
    assign add_b = is_sub ? ~req.src_data2 : req.src_data2;
    assign sum   = req.src_data1 + add_b + ex_types_pkg::word_t'(is_sub);

    assign overflow = (req.src_data1[31] == add_b[31]) && (sum[31] != req.src_data1[31]);

    // Differing signs decide directly, otherwise the difference cannot overflow
    assign slt_less  = (req.src_data1[31] != req.src_data2[31]) ? req.src_data1[31] : sum[31];
    assign sltu_less = req.src_data1 < req.src_data2;

    // CLO counts zeros of the inverted word
    assign count_src  = (req.alu_op == ex_isa_pkg::OP_CLO) ? ~req.src_data1 : req.src_data1;
    assign lead_count = lead_zeros(count_src);

    always_comb begin
        case (req.alu_op)
            ex_isa_pkg::OP_ADD,
            ex_isa_pkg::OP_ADDU,
            ex_isa_pkg::OP_SUB,
            ex_isa_pkg::OP_SUBU: begin
                arith_result = sum;
            end
            ex_isa_pkg::OP_SLT: begin
                arith_result = {31'd0, slt_less};
            end
            ex_isa_pkg::OP_SLTU: begin
                arith_result = {31'd0, sltu_less};
            end
            ex_isa_pkg::OP_CLZ,
            ex_isa_pkg::OP_CLO: begin
                arith_result = {26'd0, lead_count};
            end
            default: begin
                arith_result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- ex_mult_acc.sv
`timescale 1ns/1ps
`default_nettype none

module ex_mult_acc (
    input  logic                   clk,
    input  logic                   reset,
    input  ex_types_pkg::ex_req_t  req,
    input  ex_types_pkg::hilo_t    hilo,
    output ex_types_pkg::dword_t   product,
    output ex_types_pkg::hilo_wr_t acc_wr,
    output logic                   stall_req
);

    logic                    is_signed;
    logic                    is_acc;
    logic                    is_neg_acc;
    ex_types_pkg::word_t     mag1;
    ex_types_pkg::word_t     mag2;
    ex_types_pkg::dword_t    raw_product;
    ex_types_pkg::dword_t    acc_term;
    ex_isa_pkg::acc_state_e  acc_state;

    assign is_signed = (req.alu_op == ex_isa_pkg::OP_MUL) ||
                       (req.alu_op == ex_isa_pkg::OP_MULT) ||
                       (req.alu_op == ex_isa_pkg::OP_MADD) ||
                       (req.alu_op == ex_isa_pkg::OP_MSUB);

    assign is_neg_acc = (req.alu_op == ex_isa_pkg::OP_MSUB) ||
                        (req.alu_op == ex_isa_pkg::OP_MSUBU);

    assign is_acc = is_neg_acc ||
                    (req.alu_op == ex_isa_pkg::OP_MADD) ||
                    (req.alu_op == ex_isa_pkg::OP_MADDU);

    // Magnitudes for the signed ops
    assign mag1 = (is_signed && req.src_data1[31]) ? -req.src_data1 : req.src_data1;
    assign mag2 = (is_signed && req.src_data2[31]) ? -req.src_data2 : req.src_data2;

    assign raw_product = ex_types_pkg::dword_t'(mag1) * ex_types_pkg::dword_t'(mag2);

    assign product = (is_signed && (req.src_data1[31] ^ req.src_data2[31])) ?
                     -raw_product : raw_product;

    // First cycle asks the source to hold the instruction
    assign stall_req = !reset && is_acc && (acc_state == ex_isa_pkg::ACC_IDLE);

    assign acc_wr.en    = (acc_state == ex_isa_pkg::ACC_SUM);
    assign acc_wr.value = ex_types_pkg::hilo_t'(ex_types_pkg::dword_t'(hilo) + acc_term);

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_state <= ex_isa_pkg::ACC_IDLE;
        end else begin
            case (acc_state)
                ex_isa_pkg::ACC_IDLE: begin
                    if (is_acc) begin
                        acc_state <= ex_isa_pkg::ACC_SUM;
                    end
                end
                default: begin
                    acc_state <= ex_isa_pkg::ACC_IDLE;   // Sum lands this edge
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (is_acc && (acc_state == ex_isa_pkg::ACC_IDLE)) begin
            acc_term <= is_neg_acc ? -product : product;
        end
    end

endmodule

`default_nettype wire

//--- ex_hilo.sv
`timescale 1ns/1ps
`default_nettype none

module ex_hilo (
    input  logic                   clk,
    input  logic                   reset,
    input  ex_types_pkg::ex_req_t  req,
    input  ex_types_pkg::dword_t   product,
    input  ex_types_pkg::hilo_wr_t acc_wr,
    output ex_types_pkg::hilo_t    hilo
);

    always_ff @(posedge clk) begin
        if (reset) begin
            hilo <= '0;
        end else if (acc_wr.en) begin
            hilo <= acc_wr.value;   // Second accumulate cycle
        end else begin
            case (req.alu_op)
                ex_isa_pkg::OP_MTHI: begin
                    hilo.hi <= req.src_data1;
                end
                ex_isa_pkg::OP_MTLO: begin
                    hilo.lo <= req.src_data1;
                end
                ex_isa_pkg::OP_MULT,
                ex_isa_pkg::OP_MULTU: begin
                    hilo <= ex_types_pkg::hilo_t'(product);
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- ex_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module ex_writeback (
    input  logic                  reset,
    input  ex_types_pkg::ex_req_t req,
    input  ex_types_pkg::word_t   bitwise_result,
    input  ex_types_pkg::word_t   arith_result,
    input  logic                  overflow,
    input  ex_types_pkg::dword_t  product,
    input  ex_types_pkg::hilo_t   hilo,
    output ex_types_pkg::gpr_wb_t wb
);

    typedef enum logic [2:0] {
        GRP_NONE,
        GRP_BITWISE,
        GRP_ARITH,
        GRP_MUL,
        GRP_HI,
        GRP_LO
    } res_grp_e;

    res_grp_e grp;
    logic     trap_ovf;

    always_comb begin
        case (req.alu_op)
            ex_isa_pkg::OP_AND, ex_isa_pkg::OP_OR, ex_isa_pkg::OP_XOR, ex_isa_pkg::OP_NOR,
            ex_isa_pkg::OP_SRL, ex_isa_pkg::OP_SRA, ex_isa_pkg::OP_SLL: grp = GRP_BITWISE;
            ex_isa_pkg::OP_ADD, ex_isa_pkg::OP_ADDU, ex_isa_pkg::OP_SUB, ex_isa_pkg::OP_SUBU,
            ex_isa_pkg::OP_SLT, ex_isa_pkg::OP_SLTU,
            ex_isa_pkg::OP_CLZ, ex_isa_pkg::OP_CLO: grp = GRP_ARITH;
            ex_isa_pkg::OP_MUL:  grp = GRP_MUL;
            ex_isa_pkg::OP_MFHI: grp = GRP_HI;
            ex_isa_pkg::OP_MFLO: grp = GRP_LO;
            default:             grp = GRP_NONE;
        endcase
    end

    always_comb begin
        case (grp)
            GRP_BITWISE: wb.data = bitwise_result;
            GRP_ARITH:   wb.data = arith_result;
            GRP_MUL:     wb.data = product[31:0];   // Low word only
            GRP_HI:      wb.data = hilo.hi;
            GRP_LO:      wb.data = hilo.lo;
            default:     wb.data = '0;
        endcase
    end

    // Only the trapping forms drop the write
    assign trap_ovf = overflow && ((req.alu_op == ex_isa_pkg::OP_ADD) ||
                                   (req.alu_op == ex_isa_pkg::OP_SUB));

    assign wb.addr = req.wr_addr;
    assign wb.en   = req.wr_en && !trap_ovf && !reset;

endmodule

`default_nettype wire

//--- ex_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ex_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  ex_types_pkg::ex_req_t req,
    output ex_types_pkg::gpr_wb_t wb,
    output logic                  stall_req,
    output ex_types_pkg::hilo_t   hilo
);

    ex_types_pkg::word_t    bitwise_result;
    ex_types_pkg::word_t    arith_result;
    logic                   overflow;
    ex_types_pkg::dword_t   product;
    ex_types_pkg::hilo_wr_t acc_wr;

    ex_bitwise ex_bitwise_inst (
        .req            (req),
        .bitwise_result (bitwise_result)
    );

    ex_arith ex_arith_inst (
        .req          (req),
        .arith_result (arith_result),
        .overflow     (overflow)
    );

    ex_mult_acc ex_mult_acc_inst (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .hilo      (hilo),
        .product   (product),
        .acc_wr    (acc_wr),
        .stall_req (stall_req)
    );

    ex_hilo ex_hilo_inst (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .product (product),
        .acc_wr  (acc_wr),
        .hilo    (hilo)
    );

    ex_writeback ex_writeback_inst (
        .reset          (reset),
        .req            (req),
        .bitwise_result (bitwise_result),
        .arith_result   (arith_result),
        .overflow       (overflow),
        .product        (product),
        .hilo           (hilo),
        .wb             (wb)
    );

endmodule

`default_nettype wire

//--- ex_unit_properties.sv
`timescale 1ns/1ps
`default_nettype none

module ex_unit_properties (
    input logic                   clk,
    input logic                   reset,
    input logic                   stall_req,
    input logic                   overflow,
    input ex_types_pkg::ex_req_t  req,
    input ex_types_pkg::hilo_wr_t acc_wr,
    input ex_types_pkg::gpr_wb_t  wb
);

    stall_one_cycle: assert property (@(posedge clk) disable iff (reset)
        stall_req |=> !stall_req)
        else $error("stall_req held longer than one cycle");

    stall_in_reset: assert property (@(posedge clk) reset |-> !stall_req)
        else $error("stall_req high during reset");

    sum_after_stall: assert property (@(posedge clk) disable iff (reset)
        stall_req |=> acc_wr.en)
        else $error("no HI/LO accumulate write after stall cycle");

    add_overflow_no_write: assert property (@(posedge clk)
        (req.alu_op == ex_isa_pkg::OP_ADD && overflow) |-> !wb.en)
        else $error("register write on ADD overflow");

endmodule

bind ex_unit ex_unit_properties ex_unit_properties_inst (
    .clk       (clk),
    .reset     (reset),
    .stall_req (stall_req),
    .overflow  (overflow),
    .req       (req),
    .acc_wr    (acc_wr),
    .wb        (wb)
);

`default_nettype wire

//--- tb_ex_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_unit;

    typedef struct packed {
        ex_types_pkg::word_t data;
        logic                en;
        ex_types_pkg::dword_t hilo;
    } expect_t;

    logic                  clk;
    logic                  reset;
    ex_types_pkg::ex_req_t req;
    ex_types_pkg::gpr_wb_t wb;
    logic                  stall_req;
    ex_types_pkg::hilo_t   hilo;

    ex_types_pkg::gpr_wb_t exp_wb;
    logic                  exp_stall;
    logic                  stall_at_edge;
    ex_types_pkg::dword_t  exp_hilo;
    ex_types_pkg::dword_t  model_hilo;
    logic                  armed;
    integer                seed;
    integer                checks;
    integer                errors;
    integer                test_start;

    ex_unit ex_unit_inst (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .wb        (wb),
        .stall_req (stall_req),
        .hilo      (hilo)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Expected register write and HI/LO after one instruction
    function automatic expect_t ref_model(input ex_isa_pkg::alu_op_e op,
                                          input ex_types_pkg::word_t a,
                                          input ex_types_pkg::word_t b,
                                          input logic wr_en,
                                          input ex_types_pkg::dword_t h);
        expect_t              r;
        ex_types_pkg::word_t  s;
        ex_types_pkg::dword_t p;
        logic                 found;
        r.data = '0;
        r.en   = wr_en;
        r.hilo = h;
        p      = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        case (op)
            ex_isa_pkg::OP_AND: r.data = a & b;
            ex_isa_pkg::OP_OR:  r.data = a | b;
            ex_isa_pkg::OP_XOR: r.data = a ^ b;
            ex_isa_pkg::OP_NOR: r.data = ~(a | b);
            ex_isa_pkg::OP_SRL: r.data = b >> a[4:0];
            ex_isa_pkg::OP_SLL: r.data = b << a[4:0];
            ex_isa_pkg::OP_SRA: begin
                p      = {{32{b[31]}}, b} >> a[4:0];   // Sign fill from upper half
                r.data = p[31:0];
            end
            ex_isa_pkg::OP_ADD, ex_isa_pkg::OP_ADDU: begin
                s      = a + b;
                r.data = s;
                if (op == ex_isa_pkg::OP_ADD && a[31] == b[31] && s[31] != a[31]) r.en = 1'b0;
            end
            ex_isa_pkg::OP_SUB, ex_isa_pkg::OP_SUBU: begin
                s      = a - b;
                r.data = s;
                if (op == ex_isa_pkg::OP_SUB && a[31] != b[31] && s[31] != a[31]) r.en = 1'b0;
            end
            ex_isa_pkg::OP_SLT:  r.data = {31'd0, $signed(a) < $signed(b)};
            ex_isa_pkg::OP_SLTU: r.data = {31'd0, a < b};
            ex_isa_pkg::OP_CLZ, ex_isa_pkg::OP_CLO: begin
                found = 1'b0;
                for (int i = 31; i >= 0; i--) begin
                    if (!found && a[i] == (op == ex_isa_pkg::OP_CLO)) r.data = r.data + 1;
                    else found = 1'b1;
                end
            end
            ex_isa_pkg::OP_MUL:   r.data = p[31:0];
            ex_isa_pkg::OP_MULT:  r.hilo = p;
            ex_isa_pkg::OP_MULTU: r.hilo = {32'd0, a} * {32'd0, b};
            ex_isa_pkg::OP_MADD:  r.hilo = h + p;
            ex_isa_pkg::OP_MSUB:  r.hilo = h - p;
            ex_isa_pkg::OP_MADDU: r.hilo = h + {32'd0, a} * {32'd0, b};
            ex_isa_pkg::OP_MSUBU: r.hilo = h - {32'd0, a} * {32'd0, b};
            ex_isa_pkg::OP_MFHI:  r.data = h[63:32];
            ex_isa_pkg::OP_MFLO:  r.data = h[31:0];
            ex_isa_pkg::OP_MTHI:  r.hilo = {a, h[31:0]};
            ex_isa_pkg::OP_MTLO:  r.hilo = {h[63:32], a};
            default: ;
        endcase
        return r;
    endfunction

    // Stall level of the cycle that the edge ends
    always @(posedge clk) begin
        stall_at_edge <= stall_req;
    end

    // Reads values from the cycle that just ended
    always @(negedge clk) begin
        if (reset) begin
            checks = checks + 1;
            if (wb.en !== 1'b0 || stall_req !== 1'b0 || hilo !== '0) begin
                errors = errors + 1;
                $display("ERROR %0t: wb.en, stall_req or hilo not cleared during reset",
                         $time);
            end
        end else if (armed) begin
            checks = checks + 1;
            if (wb !== exp_wb) begin
                errors = errors + 1;
                $display("ERROR %0t: op %s wb %h expected %h", $time, req.alu_op.name(),
                         wb, exp_wb);
            end
            if (stall_at_edge !== exp_stall) begin
                errors = errors + 1;
                $display("ERROR %0t: op %s stall_req %b expected %b", $time,
                         req.alu_op.name(), stall_at_edge, exp_stall);
            end
            if (hilo !== exp_hilo) begin
                errors = errors + 1;
                $display("ERROR %0t: op %s hilo %h expected %h", $time, req.alu_op.name(),
                         hilo, exp_hilo);
            end
        end
    end

    task automatic issue(input ex_isa_pkg::alu_op_e op, input ex_types_pkg::word_t a,
                         input ex_types_pkg::word_t b);
        expect_t                r;
        ex_types_pkg::reg_addr_t addr;
        logic                   en;
        addr = ex_types_pkg::reg_addr_t'($random(seed));
        en   = ($random(seed) & 3) != 0;
        r    = ref_model(op, a, b, en, model_hilo);
        @(negedge clk);
        req    <= '{op, a, b, addr, en};
        exp_wb <= '{addr, r.data, r.en};
        armed  <= 1'b1;
        if (op inside {ex_isa_pkg::OP_MADD, ex_isa_pkg::OP_MADDU,
                       ex_isa_pkg::OP_MSUB, ex_isa_pkg::OP_MSUBU}) begin
            exp_stall <= 1'b1;
            exp_hilo  <= model_hilo;
            @(negedge clk);   // Instruction held for the sum cycle
        end
        exp_stall  <= 1'b0;
        exp_hilo   <= r.hilo;
        model_hilo  = r.hilo;
    endtask

    task automatic end_test(input string name);
        @(negedge clk);
        req   <= '{ex_isa_pkg::OP_NOP, 32'd0, 32'd0, 5'd0, 1'b0};
        armed <= 1'b0;
        #1;
        $display("test %s done, %0d mismatches", name, errors - test_start);
        test_start = errors;
    endtask

    function automatic ex_types_pkg::word_t rnd();
        return ex_types_pkg::word_t'($random(seed));
    endfunction

    initial begin
        ex_isa_pkg::alu_op_e bw_ops [7];
        ex_isa_pkg::alu_op_e ar_ops [6];
        ex_isa_pkg::alu_op_e hl_ops [5];
        ex_isa_pkg::alu_op_e acc_ops [4];
        ex_types_pkg::word_t edges [6];
        bw_ops  = '{ex_isa_pkg::OP_AND, ex_isa_pkg::OP_OR, ex_isa_pkg::OP_XOR,
                    ex_isa_pkg::OP_NOR, ex_isa_pkg::OP_SRL, ex_isa_pkg::OP_SRA,
                    ex_isa_pkg::OP_SLL};
        ar_ops  = '{ex_isa_pkg::OP_ADD, ex_isa_pkg::OP_ADDU, ex_isa_pkg::OP_SUB,
                    ex_isa_pkg::OP_SUBU, ex_isa_pkg::OP_SLT, ex_isa_pkg::OP_SLTU};
        hl_ops  = '{ex_isa_pkg::OP_MTHI, ex_isa_pkg::OP_MTLO, ex_isa_pkg::OP_MULT,
                    ex_isa_pkg::OP_MULTU, ex_isa_pkg::OP_MUL};
        acc_ops = '{ex_isa_pkg::OP_MADD, ex_isa_pkg::OP_MADDU, ex_isa_pkg::OP_MSUB,
                    ex_isa_pkg::OP_MSUBU};
        edges   = '{32'h0, 32'h1, 32'h7fffffff, 32'h80000000, 32'hffffffff, 32'h80000001};
        seed       = 30;
        checks     = 0;
        errors     = 0;
        test_start = 0;
        armed      = 1'b0;
        exp_stall  = 1'b0;
        exp_wb     = '0;
        exp_hilo   = '0;
        model_hilo = '0;
        reset      = 1'b1;
        req        = '{ex_isa_pkg::OP_MADD, 32'd3, 32'd5, 5'd1, 1'b1};   // Must not stall
        repeat (8) @(negedge clk);
        reset <= 1'b0;
        req   <= '{ex_isa_pkg::OP_NOP, 32'd0, 32'd0, 5'd0, 1'b0};
        issue(ex_isa_pkg::OP_MFHI, 32'd0, 32'd0);
        issue(ex_isa_pkg::OP_MFLO, 32'd0, 32'd0);
        end_test("reset");
        repeat (210) issue(bw_ops[$unsigned($random(seed)) % 7], rnd(), rnd());
        end_test("bitwise");
        repeat (120) issue(ar_ops[$unsigned($random(seed)) % 6], rnd(), rnd());
        foreach (edges[i]) foreach (edges[j]) foreach (ar_ops[k])
            issue(ar_ops[k], edges[i], edges[j]);
        end_test("arith");
        repeat (40) issue($random(seed) & 1 ? ex_isa_pkg::OP_CLO : ex_isa_pkg::OP_CLZ,
                          rnd(), 32'd0);
        for (int i = 0; i < 32; i++) begin
            issue(ex_isa_pkg::OP_CLZ, 32'd1 << i, 32'd0);
            issue(ex_isa_pkg::OP_CLO, ~(32'd1 << i), 32'd0);
        end
        foreach (edges[i]) issue(ex_isa_pkg::OP_CLZ, edges[i], 32'd0);
        foreach (edges[i]) issue(ex_isa_pkg::OP_CLO, edges[i], 32'd0);
        end_test("count");
        repeat (40) begin
            issue(hl_ops[$unsigned($random(seed)) % 5], rnd(), rnd());
            issue($random(seed) & 1 ? ex_isa_pkg::OP_MFHI : ex_isa_pkg::OP_MFLO, 0, 0);
        end
        end_test("hilo");
        repeat (40) begin
            issue(acc_ops[$unsigned($random(seed)) % 4], rnd(), rnd());
            issue(ex_isa_pkg::OP_MFHI, 32'd0, 32'd0);
            issue(ex_isa_pkg::OP_MFLO, 32'd0, 32'd0);
        end
        end_test("accumulate");
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #40000;
        $display("Timeout: the tests did not finish within 40 us");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
ex_isa_pkg.sv
ex_types_pkg.sv
ex_bitwise.sv
ex_arith.sv
ex_mult_acc.sv
ex_hilo.sv
ex_writeback.sv
ex_unit.sv
ex_unit_properties.sv
tb_ex_unit.sv

//--- Makefile
SRCS := $(shell cat sources.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_ex_unit: sources.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_ex_unit -f sources.f

run: obj_dir/Vtb_ex_unit
	@out="$$(./obj_dir/Vtb_ex_unit)"; echo "$$out"; \
	echo "$$out" | grep -qF "=== PASS ==="

clean:
	rm -rf obj_dir
